// ==== filelist.f ====
+incdir+include
hw/if_pkg.sv
hw/if_pc_select.sv
hw/if_fetch_unit.sv
hw/if_id_reg.sv
hw/if_stage_top.sv
dv/if_chk.sv
dv/if_monitor.sv
dv/if_tb.sv

// ==== include/if_tb_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// testbench constants: memory contents rule, test length, seed
////////////////////////////////////////////////////////////////////////////

`ifndef IF_TB_DEFS_SVH
`define IF_TB_DEFS_SVH

// memory word is the address xor a fixed pattern
`define IF_TB_DATA_PATTERN 32'hA5C3_0F96
`define IF_TB_MEM_DATA(a) ((a) ^ `IF_TB_DATA_PATTERN)
// bus error on every word whose address bits 7:2 are all ones
`define IF_TB_MEM_ERR(a) (&(a[7:2]))
`define IF_TB_NUM_INSTR 1500
`define IF_TB_CYC_PER_INSTR 20
`define IF_TB_TIMEOUT_EXTRA 200
`define IF_TB_SEED 32'h756d654f

`endif

// ==== dv/if_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch stage testbench: clock, reset, random redirects and stalls,
// instruction memory responder and closing report
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_tb_defs.svh"

module if_tb;

  logic                clk_i, rst_ni, req_i, pc_set_i;
  logic         [31:0] boot_addr_i, branch_target_ex_i;
  logic         [31:0] csr_mepc_i, csr_depc_i, csr_mtvec_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  if_pkg::exc_cause_t  exc_cause_i;
  logic                csr_mtvec_init_o, instr_req_o, instr_gnt_i;
  logic         [31:0] instr_addr_o, pc_if_o;
  if_pkg::instr_rsp_t  instr_rsp_i;
  logic                id_in_ready_i, instr_valid_clear_i;
  logic                instr_valid_id_o, instr_new_id_o, if_busy_o;
  if_pkg::id_instr_t   id_o;

  logic        [31:0] rng;
  logic        [31:0] granted [$];
  logic               boot_done;
  int unsigned        cycle_cnt;
  int unsigned        num_new, pc_errs, data_errs, flag_errs, chk_errs;

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and memory responder
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : drive
    logic [31:0] ctl;
    logic [31:0] addr;
    logic  [2:0] sel;
    cycle_cnt++;
    if (rst_ni) begin
      ctl = xorshift32();
      sel = 3'(xorshift32() % 32'd5);
      // boot redirect first, then about one redirect in 32 cycles
      pc_set_i     <= !boot_done || ctl[4:0] == 5'd0;
      pc_mux_i     <= boot_done ? if_pkg::pc_sel_e'(sel) : if_pkg::PC_BOOT;
      boot_done    = 1'b1;
      req_i        <= 1'b1;
      exc_pc_mux_i <= if_pkg::exc_pc_sel_e'(ctl[7:6]);
      exc_cause_i  <= ctl[21:16];
      boot_addr_i        <= xorshift32();
      branch_target_ex_i <= xorshift32();
      csr_mepc_i         <= xorshift32();
      csr_depc_i         <= xorshift32();
      csr_mtvec_i        <= xorshift32();
      id_in_ready_i       <= ctl[9:8] != 2'd0;
      instr_valid_clear_i <= ctl[10];
      instr_gnt_i         <= ctl[12:11] != 2'd0;
      // oldest granted word answers after a random delay
      if (granted.size() > 0 && ctl[14:13] != 2'd0) begin
        addr = granted.pop_front();
        instr_rsp_i <= '{rvalid: 1'b1, rdata: `IF_TB_MEM_DATA(addr), err: `IF_TB_MEM_ERR(addr)};
      end else begin
        instr_rsp_i <= '{rvalid: 1'b0, rdata: xorshift32(), err: ctl[15]};
      end
      if (instr_req_o && instr_gnt_i) begin
        granted.push_back(instr_addr_o);
      end
    end
  end

  initial begin
    rng = `IF_TB_SEED;
    boot_done = 1'b0;
    cycle_cnt = 0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = if_pkg::PC_BOOT;
    exc_pc_mux_i = if_pkg::EXC_PC_EXC;
    exc_cause_i = '0;
    boot_addr_i = 32'h0;
    branch_target_ex_i = 32'h0;
    csr_mepc_i = 32'h0;
    csr_depc_i = 32'h0;
    csr_mtvec_i = 32'h0;
    instr_gnt_i = 1'b0;
    instr_rsp_i = '0;
    id_in_ready_i = 1'b0;
    instr_valid_clear_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // sampled away from the rising edge
    while (num_new < `IF_TB_NUM_INSTR &&
           cycle_cnt < `IF_TB_NUM_INSTR * `IF_TB_CYC_PER_INSTR + `IF_TB_TIMEOUT_EXTRA) begin
      @(negedge clk_i);
    end
    if (num_new < `IF_TB_NUM_INSTR) begin
      $display("timeout: only %0d of %0d instructions reached ID in %0d cycles",
               num_new, `IF_TB_NUM_INSTR, cycle_cnt);
    end
    chk_errs = UUT.u_chk.fail_cnt;
    $display("errors: pc %0d, data %0d, flags %0d, assertions %0d",
             pc_errs, data_errs, flag_errs, chk_errs);
    if (num_new < `IF_TB_NUM_INSTR || pc_errs + data_errs + flag_errs + chk_errs != 0) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

  if_stage_top UUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i), .boot_addr_i (boot_addr_i),
    .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .exc_cause_i (exc_cause_i), .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i (csr_mepc_i), .csr_depc_i (csr_depc_i), .csr_mtvec_i (csr_mtvec_i),
    .csr_mtvec_init_o (csr_mtvec_init_o), .instr_req_o (instr_req_o),
    .instr_addr_o (instr_addr_o), .instr_gnt_i (instr_gnt_i), .instr_rsp_i (instr_rsp_i),
    .id_in_ready_i (id_in_ready_i), .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o (instr_valid_id_o), .instr_new_id_o (instr_new_id_o),
    .id_o (id_o), .pc_if_o (pc_if_o), .if_busy_o (if_busy_o)
  );

  if_monitor u_monitor (
    .clk_i (clk_i), .rst_ni (rst_ni), .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i),
    .exc_pc_mux_i (exc_pc_mux_i), .exc_cause_i (exc_cause_i), .boot_addr_i (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i), .csr_mepc_i (csr_mepc_i),
    .csr_depc_i (csr_depc_i), .csr_mtvec_i (csr_mtvec_i),
    .instr_valid_clear_i (instr_valid_clear_i), .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o (instr_req_o), .if_busy_o (if_busy_o),
    .instr_valid_id_o (instr_valid_id_o), .instr_new_id_o (instr_new_id_o), .id_o (id_o),
    .pc_if_o (pc_if_o),
    .num_new_o (num_new), .pc_errs_o (pc_errs), .data_errs_o (data_errs),
    .flag_errs_o (flag_errs)
  );

endmodule

// ==== dv/if_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// reference model of the fetch stage outputs
// expected pc stream, memory contents and ID flags, with error counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_tb_defs.svh"

module if_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       pc_set_i,
  input  if_pkg::pc_sel_e            pc_mux_i,
  input  if_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  if_pkg::exc_cause_t         exc_cause_i,
  input  logic                [31:0] boot_addr_i,
  input  logic                [31:0] branch_target_ex_i,
  input  logic                [31:0] csr_mepc_i,
  input  logic                [31:0] csr_depc_i,
  input  logic                [31:0] csr_mtvec_i,
  input  logic                       instr_valid_clear_i,
  input  logic                       csr_mtvec_init_o,
  input  logic                       instr_req_o,
  input  logic                       if_busy_o,
  input  logic                       instr_valid_id_o,
  input  logic                       instr_new_id_o,
  input  if_pkg::id_instr_t          id_o,
  input  logic                [31:0] pc_if_o,
  output int unsigned                num_new_o,
  output int unsigned                pc_errs_o,
  output int unsigned                data_errs_o,
  output int unsigned                flag_errs_o
);

  logic [31:0] exp_pc;
  logic        started;
  logic        exp_valid, clear_prev, pc_set_prev;
  // queue head address seen in the previous cycle
  logic [31:0] pc_if_prev;

  // target of a redirect, worked out from the current redirect inputs
  function automatic logic [31:0] redirect_target();
    logic [31:0] base;
    logic [31:0] vec;
    logic [31:0] tgt;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    vec  = exc_cause_i.irq_int ? 32'(if_pkg::IRQ_NM_CAUSE) : 32'(exc_cause_i.lower_cause);
    case (pc_mux_i)
      if_pkg::PC_BOOT: tgt = {boot_addr_i[31:8], if_pkg::BOOT_OFFSET};
      if_pkg::PC_JUMP: tgt = branch_target_ex_i;
      if_pkg::PC_EXC: begin
        case (exc_pc_mux_i)
          if_pkg::EXC_PC_EXC: tgt = base;
          if_pkg::EXC_PC_IRQ: tgt = base + 32'd4 * vec;
          if_pkg::EXC_PC_DBD: tgt = if_pkg::DM_HALT_ADDR;
          default:            tgt = if_pkg::DM_EXC_ADDR;
        endcase
      end
      if_pkg::PC_ERET: tgt = csr_mepc_i;
      default:         tgt = csr_depc_i;
    endcase
    return tgt & ~32'h3;
  endfunction

  task automatic report_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("Fail %s: got %h, expected %h", sig, got, exp);
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      // reset forces the bus request and the ID flags low
      if (instr_req_o | if_busy_o | instr_valid_id_o | instr_new_id_o) begin
        $display("reset did not clear the request, busy, valid and new outputs");
        flag_errs_o++;
      end
      started     = 1'b0;
      exp_valid   = 1'b0;
      clear_prev  = 1'b0;
      pc_set_prev = 1'b0;
    end else begin
      // mtvec init only with a boot redirect
      if (csr_mtvec_init_o !== (pc_set_i && pc_mux_i == if_pkg::PC_BOOT)) begin
        report_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
                     32'(pc_set_i && pc_mux_i == if_pkg::PC_BOOT));
        flag_errs_o++;
      end
      // valid is set by a word taken outside a redirect, held until cleared
      exp_valid = (instr_new_id_o & ~pc_set_prev) | (exp_valid & ~clear_prev);
      if (instr_valid_id_o !== exp_valid) begin
        report_value("instr_valid_id_o", 32'(instr_valid_id_o), 32'(exp_valid));
        flag_errs_o++;
        exp_valid = instr_valid_id_o;
      end
      if (instr_new_id_o) begin
        num_new_o++;
        if (!started) begin
          $display("instruction reached ID before the first redirect");
          pc_errs_o++;
        end else begin
          if (id_o.pc !== exp_pc) begin
            report_value("id_o.pc", id_o.pc, exp_pc);
            pc_errs_o++;
          end
          // the queue head offered at acceptance was the expected word
          if (pc_if_prev !== exp_pc) begin
            report_value("pc_if_o", pc_if_prev, exp_pc);
            pc_errs_o++;
          end
        end
        if (id_o.instr !== `IF_TB_MEM_DATA(id_o.pc)) begin
          report_value("id_o.instr", id_o.instr, `IF_TB_MEM_DATA(id_o.pc));
          data_errs_o++;
        end
        if (id_o.fetch_err !== `IF_TB_MEM_ERR(id_o.pc)) begin
          report_value("id_o.fetch_err", 32'(id_o.fetch_err), 32'(`IF_TB_MEM_ERR(id_o.pc)));
          data_errs_o++;
        end
        // resync on the observed pc so one slip is reported once
        exp_pc = id_o.pc + 32'd4;
      end
      // a word shown with the redirect is still from the old stream
      if (pc_set_i) begin
        exp_pc  = redirect_target();
        started = 1'b1;
      end
      clear_prev  = instr_valid_clear_i;
      pc_set_prev = pc_set_i;
      pc_if_prev  = pc_if_o;
    end
  end

endmodule

// ==== dv/if_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// bus and ID output assertions, bound into the fetch stage top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_chk (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               instr_req_o,
  input logic        [31:0] instr_addr_o,
  input logic               instr_gnt_i,
  input if_pkg::instr_rsp_t instr_rsp_i,
  input logic               instr_valid_id_o,
  input logic               instr_new_id_o
);

  // failed assertions, read by the testbench top
  int unsigned fail_cnt = 0;
  // granted requests still waiting for data
  logic [2:0]  open_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_cnt <= 3'd0;
    end else begin
      open_cnt <= open_cnt + {2'b0, instr_req_o & instr_gnt_i} - {2'b0, instr_rsp_i.rvalid};
    end
  end

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("instruction request dropped or moved before its grant");
      fail_cnt++;
    end

  // only whole words on the bus
  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else begin
      $error("instruction address not word aligned");
      fail_cnt++;
    end

  rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rsp_i.rvalid |-> open_cnt != 3'd0)
    else begin
      $error("response without an open granted request");
      fail_cnt++;
    end

  new_is_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o)
    else begin
      $error("new instruction flagged in ID while not valid");
      fail_cnt++;
    end

endmodule

bind if_stage_top if_chk u_chk (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .instr_req_o      (instr_req_o),
  .instr_addr_o     (instr_addr_o),
  .instr_gnt_i      (instr_gnt_i),
  .instr_rsp_i      (instr_rsp_i),
  .instr_valid_id_o (instr_valid_id_o),
  .instr_new_id_o   (instr_new_id_o)
);

// ==== hw/if_stage_top.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch stage top level
// pc selection, prefetch unit and IF-ID register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                [31:0] boot_addr_i,
  // redirect control
  input  logic                       pc_set_i,
  input  if_pkg::pc_sel_e            pc_mux_i,
  input  if_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  if_pkg::exc_cause_t         exc_cause_i,
  input  logic                [31:0] branch_target_ex_i,
  input  logic                [31:0] csr_mepc_i,
  input  logic                [31:0] csr_depc_i,
  input  logic                [31:0] csr_mtvec_i,
  output logic                       csr_mtvec_init_o,
  // instruction bus
  output logic                       instr_req_o,
  output logic                [31:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  if_pkg::instr_rsp_t         instr_rsp_i,
  // ID side
  input  logic                       id_in_ready_i,
  input  logic                       instr_valid_clear_i,
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output if_pkg::id_instr_t          id_o,
  output logic                [31:0] pc_if_o,
  output logic                       if_busy_o
);

  logic           branch;
  logic    [31:0] branch_addr;
  logic           fetch_valid;
  logic           fetch_ready;
  if_pkg::fetch_t fetch;

  if_pc_select u_pc_select (
    .boot_addr_i        (boot_addr_i),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .branch_o           (branch),
    .branch_addr_o      (branch_addr),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  if_fetch_unit u_fetch_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .ready_i       (fetch_ready),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rsp_i   (instr_rsp_i),
    .valid_o       (fetch_valid),
    .fetch_o       (fetch),
    .busy_o        (if_busy_o)
  );

  if_id_reg u_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_i             (fetch),
    .fetch_ready_o       (fetch_ready),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_o                (id_o)
  );

  // pc of the word at the queue head
  assign pc_if_o = fetch.addr;

endmodule

// ==== hw/if_id_reg.sv ====
////////////////////////////////////////////////////////////////////////////
// IF-ID pipeline register
// valid and new flags, instruction, pc and fetch error
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_id_reg (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fetch_valid_i,
  input  if_pkg::fetch_t    fetch_i,
  output logic              fetch_ready_o,
  input  logic              id_in_ready_i,
  input  logic              pc_set_i,
  input  logic              instr_valid_clear_i,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output if_pkg::id_instr_t id_o
);

  logic              accept;
  logic              valid_d, valid_q;
  logic              new_d, new_q;
  if_pkg::id_instr_t id_d, id_q;

  // ID takes a word whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign accept        = fetch_valid_i & id_in_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////////////////////

  // a redirect squashes the word taken in the same cycle
  // otherwise valid holds until the core clears it
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  // one cycle pulse per word entering ID
  assign new_d = accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // contents
  ////////////////////////////////////////////////////////////////////////////

  assign id_d = '{instr: fetch_i.rdata, pc: fetch_i.addr, fetch_err: fetch_i.err};

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= id_d;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign id_o             = id_q;

endmodule

// ==== hw/if_fetch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction prefetch over the request/grant/response bus
// tracks requests in flight, drops responses made stale by a redirect
// and buffers returned words in a two entry queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_fetch_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      branch_i,
  input  logic               [31:0] branch_addr_i,
  input  logic                      ready_i,
  output logic                      instr_req_o,
  output logic               [31:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  if_pkg::instr_rsp_t        instr_rsp_i,
  output logic                      valid_o,
  output if_pkg::fetch_t            fetch_o,
  output logic                      busy_o
);

  // bus request, registered
  logic           req_q, req_d;
  logic    [31:0] addr_q, addr_d;
  // address of the next word to be requested
  logic    [31:0] fetch_addr_q, fetch_addr_d;
  // address of the next non-stale response
  logic    [31:0] rsp_addr_q, rsp_addr_d;
  // pending request was issued before the last redirect
  logic           pend_stale_q, pend_stale_d;
  // granted requests waiting for a response, and how many of them to drop
  logic     [1:0] out_cnt_q, out_cnt_d;
  logic     [1:0] stale_cnt_q, stale_cnt_d;
  // queue fill level, entry 0 is the head
  logic     [1:0] q_cnt_q, q_cnt_d;
  if_pkg::fetch_t q_mem [2];
  if_pkg::fetch_t q_wdata;
  logic     [1:0] wr_ptr;

  logic           gnt;
  logic           rsp;
  logic           rsp_stale;
  logic           push;
  logic           pop;
  logic           launch;
  logic     [2:0] in_flight;

  ////////////////////////////////////////////////////////////////////////////
  // handshake events
  ////////////////////////////////////////////////////////////////////////////

  assign gnt       = req_q & instr_gnt_i;
  assign rsp       = instr_rsp_i.rvalid;
  assign rsp_stale = rsp & (stale_cnt_q != 2'd0);
  // a response in the redirect cycle belongs to the old stream
  assign push      = rsp & ~rsp_stale & ~branch_i;

  // head is hidden as soon as the core redirects
  assign valid_o = (q_cnt_q != 2'd0) & ~branch_i;
  assign pop     = valid_o & ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////////

  assign out_cnt_d = out_cnt_q + {1'b0, gnt} - {1'b0, rsp};

  always_comb begin
    if (branch_i) begin
      // everything granted so far now belongs to the old stream
      stale_cnt_d  = out_cnt_d;
      // an ungranted request still completes, its data is dropped later
      pend_stale_d = req_q & ~gnt;
      q_cnt_d      = 2'd0;
    end else begin
      stale_cnt_d  = stale_cnt_q - {1'b0, rsp_stale} + {1'b0, gnt & pend_stale_q};
      pend_stale_d = pend_stale_q & ~gnt;
      q_cnt_d      = q_cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address tracking and request launch
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (branch_i) begin
      fetch_addr_d = branch_addr_i;
      rsp_addr_d   = branch_addr_i;
    end else begin
      // a stale grant does not move the new stream
      fetch_addr_d = (gnt & ~pend_stale_q) ? fetch_addr_q + 32'd4 : fetch_addr_q;
      rsp_addr_d   = push ? rsp_addr_q + 32'd4 : rsp_addr_q;
    end
  end

  // queued words plus granted requests, as seen next cycle
  assign in_flight = {1'b0, q_cnt_d} + {1'b0, out_cnt_d};

  // new request only when the bus is free and the queue has room for it
  assign launch = req_i & (~req_q | gnt) &
                  (in_flight < 3'(if_pkg::MAX_OUTSTANDING));

  // a raised request holds its address until granted
  assign req_d  = launch | (req_q & ~gnt);
  assign addr_d = launch ? fetch_addr_d : addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q        <= 1'b0;
      addr_q       <= '0;
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
      pend_stale_q <= 1'b0;
      out_cnt_q    <= 2'd0;
      stale_cnt_q  <= 2'd0;
      q_cnt_q      <= 2'd0;
    end else begin
      req_q        <= req_d;
      addr_q       <= addr_d;
      fetch_addr_q <= fetch_addr_d;
      rsp_addr_q   <= rsp_addr_d;
      pend_stale_q <= pend_stale_d;
      out_cnt_q    <= out_cnt_d;
      stale_cnt_q  <= stale_cnt_d;
      q_cnt_q      <= q_cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch queue
  ////////////////////////////////////////////////////////////////////////////

  // write slot accounts for a pop in the same cycle
  assign wr_ptr  = q_cnt_q - {1'b0, pop};
  assign q_wdata = '{addr: rsp_addr_q, rdata: instr_rsp_i.rdata, err: instr_rsp_i.err};

  always_ff @(posedge clk_i) begin
    // shift towards the head on pop
    if (pop) begin
      q_mem[0] <= q_mem[1];
    end
    if (push) begin
      q_mem[wr_ptr[0]] <= q_wdata;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;
  assign fetch_o      = q_mem[0];
  assign busy_o       = req_q | (out_cnt_q != 2'd0);

endmodule

// ==== hw/if_pc_select.sv ====
////////////////////////////////////////////////////////////////////////////
// next fetch address selection on a pc redirect
// trap vector computation and mtvec init request on boot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_pc_select (
  input  logic                [31:0] boot_addr_i,
  input  logic                       pc_set_i,
  input  if_pkg::pc_sel_e            pc_mux_i,
  input  if_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  if_pkg::exc_cause_t         exc_cause_i,
  input  logic                [31:0] branch_target_ex_i,
  input  logic                [31:0] csr_mepc_i,
  input  logic                [31:0] csr_depc_i,
  input  logic                [31:0] csr_mtvec_i,
  output logic                       branch_o,
  output logic                [31:0] branch_addr_o,
  output logic                       csr_mtvec_init_o
);

  logic [31:0] boot_pc;
  logic [4:0]  irq_vec;
  logic [31:0] exc_pc;
  logic [31:0] next_pc;

  // boot pc sits at a fixed offset in the 256 byte boot block
  assign boot_pc = {boot_addr_i[31:8], if_pkg::BOOT_OFFSET};

  ////////////////////////////////////////////////////////////////////////////
  // trap vectors
  ////////////////////////////////////////////////////////////////////////////

  // internal interrupts all share the non-maskable slot
  assign irq_vec = exc_cause_i.irq_int ? if_pkg::IRQ_NM_CAUSE : exc_cause_i.lower_cause;

  always_comb begin
    unique case (exc_pc_mux_i)
      // base of the vector table, mtvec low byte ignored
      if_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      // base plus 4 * vector index
      if_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
      if_pkg::EXC_PC_DBD:     exc_pc = if_pkg::DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = if_pkg::DM_EXC_ADDR;
      default:                exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next address mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: next_pc = boot_pc;
      if_pkg::PC_JUMP: next_pc = branch_target_ex_i;
      // trap entry
      if_pkg::PC_EXC:  next_pc = exc_pc;
      // return from trap
      if_pkg::PC_ERET: next_pc = csr_mepc_i;
      // return from debug mode
      if_pkg::PC_DRET: next_pc = csr_depc_i;
      default:         next_pc = boot_pc;
    endcase
  end

  // only whole words are fetched
  assign branch_o      = pc_set_i;
  assign branch_addr_o = {next_pc[31:2], 2'b00};

  // csr file loads mtvec from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

// ==== hw/if_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch stage shared definitions
// pc and vector selector enums, bus response and fetch structs,
// boot, debug and fetch queue constants
////////////////////////////////////////////////////////////////////////////

package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // selectors
  ////////////////////////////////////////////////////////////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap vector when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // trap cause, irq_int marks an internal interrupt
  typedef struct packed {
    logic       irq_int;
    logic [4:0] lower_cause;
  } exc_cause_t;

  // instruction memory response
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } instr_rsp_t;

  // one fetched word with its address
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
  } fetch_t;

  // IF-ID register contents
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        fetch_err;
  } id_instr_t;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  // low byte of the boot pc
  localparam logic [7:0]  BOOT_OFFSET     = 8'h80;
  // debug module entry points
  localparam logic [31:0] DM_HALT_ADDR    = 32'h1A110800;
  localparam logic [31:0] DM_EXC_ADDR     = 32'h1A110808;
  // vector index used by all internal interrupts
  localparam logic [4:0]  IRQ_NM_CAUSE    = 5'd31;
  // fetch queue depth, also the bound on requests in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

endpackage
